// File: build.f
common/systolic_pkg.sv
design/data_feeder.sv
systolic_array/pe.sv
systolic_array/pe_grid.sv
design/systolic_ctrl.sv
design/systolic.sv
verif/systolic_sva.sv
verif/systolic_tb.sv

// File: Makefile
TOP = systolic_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f build.f -o V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST OK" sim.log; then echo "Simulation ended without a verdict"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// File: verif/systolic_tb.sv
`timescale 1ns/100ps

module systolic_tb
    import systolic_pkg::*;
();

    localparam int random_jobs = 200;
    localparam int hold_jobs = 8;
    localparam int max_idle = 16;
    localparam int done_latency = 12;   // Edges from accept to done.
    localparam int done_wait_limit = 40;
    localparam int job_count = random_jobs + 3 + 1 + hold_jobs;
    localparam int cycle_limit = job_count * 14 + hold_jobs * max_idle + 50;

    logic       clk;
    logic       reset;
    logic       valid_in;
    matrix_in_t matrix_A;
    matrix_in_t matrix_B;
    result_t    y;
    logic       done;
    logic       done_matrix_mult;

    int cycle_count = 0;
    int checks = 0;
    int value_errors = 0;
    int other_errors = 0;

    systolic uut (
        .clk              (clk),
        .reset            (reset),
        .valid_in         (valid_in),
        .matrix_A         (matrix_A),
        .matrix_B         (matrix_B),
        .y                (y),
        .done             (done),
        .done_matrix_mult (done_matrix_mult)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: run went past %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic elem_t element(input matrix_in_t m, input int row, input int col);
        return m[$bits(matrix_in_t) - elem_w * (row * n_dim + col + 1) +: elem_w];
    endfunction

    // Row-major product, element (0,0) in the top word.
    function automatic result_t model_product(input matrix_in_t a, input matrix_in_t b);
        result_t r;
        acc_t sum;
        r = '0;
        for (int i = 0; i < n_dim; i++) begin
            for (int j = 0; j < n_dim; j++) begin
                sum = '0;
                for (int k = 0; k < n_dim; k++)
                    sum = sum + acc_t'(element(a, i, k)) * acc_t'(element(b, k, j));
                r[$bits(result_t) - acc_w * (i * n_dim + j + 1) +: acc_w] = sum;
            end
        end
        return r;
    endfunction

    function automatic result_t widen_matrix(input matrix_in_t m);
        result_t r;
        r = '0;
        for (int i = 0; i < n_dim; i++)
            for (int j = 0; j < n_dim; j++)
                r[$bits(result_t) - acc_w * (i * n_dim + j + 1) +: acc_w] =
                    acc_t'(element(m, i, j));
        return r;
    endfunction

    function automatic matrix_in_t random_matrix();
        matrix_in_t m;
        for (int w = 0; w < 4; w++)
            m[32 * w +: 32] = $urandom;
        return m;
    endfunction

    task automatic check_result(input result_t expected);
        checks++;
        assert (y === expected) else begin
            $display("FAIL y: expected %h, got %h", expected, y);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        checks++;
        assert (actual === expected) else begin
            $display("FAIL %s: expected %h, got %h", name, expected, actual);
            value_errors++;
        end
    endtask

    // Starts one job and waits for done. With disturb set, valid_in pulses
    // and the operand inputs change while the grid runs.
    task automatic run_job(input matrix_in_t a, input matrix_in_t b,
                           input result_t expected, input bit disturb);
        int edges;
        bit got_done;
        @(posedge clk);
        valid_in <= 1'b1;
        matrix_A <= a;
        matrix_B <= b;
        @(posedge clk);                 // Accepting edge.
        valid_in <= 1'b0;
        @(negedge clk);
        check_flag("done_matrix_mult", 1'b0, done_matrix_mult);
        edges = 0;
        got_done = 1'b0;
        while (!got_done && edges < done_wait_limit) begin
            @(posedge clk);
            edges++;
            if (disturb && edges <= 9) begin
                valid_in <= ($urandom_range(0, 1) == 1);
                matrix_A <= random_matrix();
                matrix_B <= random_matrix();
            end else begin
                valid_in <= 1'b0;
            end
            @(negedge clk);
            got_done = done;
        end
        if (!got_done) begin
            $display("done never rose within %0d cycles of an accepted job", done_wait_limit);
            other_errors++;
        end else begin
            checks++;
            assert (edges == done_latency) else begin
                $display("FAIL done latency: expected %h, got %h", done_latency, edges);
                value_errors++;
            end
            check_result(expected);
            check_flag("done_matrix_mult", 1'b1, done_matrix_mult);
        end
    endtask

    // Result and flag must sit still while nothing new is started.
    task automatic hold_idle(input int cycles, input result_t expected);
        repeat (cycles) begin
            @(posedge clk);
            @(negedge clk);
            check_result(expected);
            check_flag("done_matrix_mult", 1'b1, done_matrix_mult);
            check_flag("done", 1'b0, done);
        end
    endtask

    initial begin
        matrix_in_t a;
        matrix_in_t b;
        result_t expected;
        void'($urandom(32'h3a5b));
        reset = 1'b1;
        valid_in = 1'b0;
        matrix_A = '0;
        matrix_B = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_flag("done", 1'b0, done);
        check_flag("done_matrix_mult", 1'b0, done_matrix_mult);
        check_result('0);

        for (int n = 0; n < random_jobs; n++) begin
            a = random_matrix();
            b = random_matrix();
            run_job(a, b, model_product(a, b), 1'b0);
        end

        // Corner operands with products known by hand.
        expected = {(n_dim * n_dim){acc_t'(n_dim * 8'hff * 8'hff)}};
        run_job('1, '1, expected, 1'b0);
        a = random_matrix();
        run_job(a, 128'h01000000_00010000_00000100_00000001, widen_matrix(a), 1'b0);
        run_job('0, random_matrix(), '0, 1'b0);

        a = random_matrix();
        b = random_matrix();
        run_job(a, b, model_product(a, b), 1'b1);

        for (int n = 0; n < hold_jobs; n++) begin
            a = random_matrix();
            b = random_matrix();
            expected = model_product(a, b);
            run_job(a, b, expected, 1'b0);
            hold_idle($urandom_range(1, max_idle), expected);
        end

        $display("Checks run: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: verif/systolic_sva.sv
`timescale 1ns/100ps

module systolic_sva
    import systolic_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input logic        valid_in,
    input logic        load,
    input logic        shift_en,
    input logic        done,
    input logic        done_matrix_mult,
    input ctrl_state_t state
);

    // A finished job is announced for a single cycle.
    done_single_cycle: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
        else $error("done stayed high for more than one cycle");

    // Lanes start to move only right after a load.
    shift_only_in_run: assert property (@(posedge clk) disable iff (reset)
        $rose(shift_en) |-> $past(load))
        else $error("shift_en rose without a preceding load");

    // The run phase lasts exactly run_cycles cycles after the load.
    run_phase_length: assert property (@(posedge clk) disable iff (reset)
        $fell(shift_en) |-> $past(load, run_cycles + 1))
        else $error("shift_en did not last exactly one run phase");

    // The result flag drops only when a new job is taken from idle.
    flag_falls_on_accept: assert property (@(posedge clk) disable iff (reset)
        $fell(done_matrix_mult) |-> $past((state == st_idle) && valid_in))
        else $error("done_matrix_mult fell without an accepted job");

endmodule

bind systolic_ctrl systolic_sva u_sva (
    .clk              (clk),
    .reset            (reset),
    .valid_in         (valid_in),
    .load             (load),
    .shift_en         (shift_en),
    .done             (done),
    .done_matrix_mult (done_matrix_mult),
    .state            (state)
);

// File: design/systolic.sv
`timescale 1ns/100ps

module systolic
    import systolic_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       valid_in,
    input  matrix_in_t matrix_A,
    input  matrix_in_t matrix_B,
    output result_t    y,
    output logic       done,
    output logic       done_matrix_mult
);

    localparam int row_w = n_dim * elem_w;

    lane_t row_lane [n_dim];
    lane_t col_lane [n_dim];
    elem_t row_feed [n_dim];
    elem_t col_feed [n_dim];

    logic load;
    logic shift_en;
    logic clear_acc;

    // Place four bytes with idx leading zero slots.
    function automatic lane_t skew(input logic [row_w-1:0] bytes, input int idx);
        lane_t lane;
        lane = {bytes, {(n_dim-1)*elem_w{1'b0}}};
        return lane >> (elem_w * idx);
    endfunction

    // Gather column j of B, row 0 first.
    function automatic logic [row_w-1:0] column_of(input matrix_in_t m, input int j);
        logic [row_w-1:0] col;
        for (int k = 0; k < n_dim; k++)
            col[row_w-1-elem_w*k -: elem_w] = m[$bits(matrix_in_t)-1-row_w*k-elem_w*j -: elem_w];
        return col;
    endfunction

    always_comb begin
        for (int i = 0; i < n_dim; i++) begin
            row_lane[i] = skew(matrix_A[$bits(matrix_in_t)-1-row_w*i -: row_w], i);
            col_lane[i] = skew(column_of(matrix_B, i), i);
        end
    end

    // Row feeders for A.
    data_feeder fr1 (.clk(clk), .reset(reset), .load(load), .enable(shift_en),
                     .data_in(row_lane[0]), .data_out(row_feed[0]));
    data_feeder fr2 (.clk(clk), .reset(reset), .load(load), .enable(shift_en),
                     .data_in(row_lane[1]), .data_out(row_feed[1]));
    data_feeder fr3 (.clk(clk), .reset(reset), .load(load), .enable(shift_en),
                     .data_in(row_lane[2]), .data_out(row_feed[2]));
    data_feeder fr4 (.clk(clk), .reset(reset), .load(load), .enable(shift_en),
                     .data_in(row_lane[3]), .data_out(row_feed[3]));

    // Column feeders for B.
    data_feeder fc1 (.clk(clk), .reset(reset), .load(load), .enable(shift_en),
                     .data_in(col_lane[0]), .data_out(col_feed[0]));
    data_feeder fc2 (.clk(clk), .reset(reset), .load(load), .enable(shift_en),
                     .data_in(col_lane[1]), .data_out(col_feed[1]));
    data_feeder fc3 (.clk(clk), .reset(reset), .load(load), .enable(shift_en),
                     .data_in(col_lane[2]), .data_out(col_feed[2]));
    data_feeder fc4 (.clk(clk), .reset(reset), .load(load), .enable(shift_en),
                     .data_in(col_lane[3]), .data_out(col_feed[3]));

    pe_grid u_grid (
        .clk    (clk),
        .reset  (reset),
        .clear  (clear_acc),
        .a_row0 (row_feed[0]),
        .a_row1 (row_feed[1]),
        .a_row2 (row_feed[2]),
        .a_row3 (row_feed[3]),
        .b_col0 (col_feed[0]),
        .b_col1 (col_feed[1]),
        .b_col2 (col_feed[2]),
        .b_col3 (col_feed[3]),
        .result (y)
    );

    systolic_ctrl u_ctrl (
        .clk              (clk),
        .reset            (reset),
        .valid_in         (valid_in),
        .load             (load),
        .shift_en         (shift_en),
        .clear_acc        (clear_acc),
        .done             (done),
        .done_matrix_mult (done_matrix_mult)
    );

endmodule

// File: design/systolic_ctrl.sv
`timescale 1ns/100ps

module systolic_ctrl
    import systolic_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic valid_in,
    output logic load,
    output logic shift_en,
    output logic clear_acc,
    output logic done,
    output logic done_matrix_mult
);

    ctrl_state_t state;
    run_cnt_t run_cnt;

    logic accept;
    logic run_last;

    // New jobs are taken only from idle.
    assign accept = (state == st_idle) && valid_in;
    assign run_last = (run_cnt == run_cnt_t'(run_cycles - 1));

    assign load = (state == st_load);
    assign clear_acc = (state == st_load);   // Clear together with the lane capture.
    assign shift_en = (state == st_run);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            run_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (valid_in)
                        state <= st_load;
                end
                st_load: begin
                    run_cnt <= '0;
                    state <= st_run;
                end
                st_run: begin
                    if (run_last) begin
                        state <= st_finish;
                    end else begin
                        run_cnt <= run_cnt + 1'b1;
                    end
                end
                st_finish: begin
                    state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Last product lands in the corner cell at the edge leaving finish.
    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
            done_matrix_mult <= 1'b0;
        end else begin
            done <= (state == st_finish);
            if (state == st_finish)
                done_matrix_mult <= 1'b1;
            else if (accept)
                done_matrix_mult <= 1'b0;   // Held until the next job starts.
        end
    end

endmodule

// File: systolic_array/pe_grid.sv
`timescale 1ns/100ps

module pe_grid
    import systolic_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    clear,
    input  elem_t   a_row0,
    input  elem_t   a_row1,
    input  elem_t   a_row2,
    input  elem_t   a_row3,
    input  elem_t   b_col0,
    input  elem_t   b_col1,
    input  elem_t   b_col2,
    input  elem_t   b_col3,
    output result_t result
);

    // Horizontal and vertical operand links, one extra slot at the far edge.
    elem_t a_link [n_dim][n_dim+1];
    elem_t b_link [n_dim+1][n_dim];

    acc_t cell_acc [n_dim][n_dim];

    assign a_link[0][0] = a_row0;
    assign a_link[1][0] = a_row1;
    assign a_link[2][0] = a_row2;
    assign a_link[3][0] = a_row3;

    assign b_link[0][0] = b_col0;
    assign b_link[0][1] = b_col1;
    assign b_link[0][2] = b_col2;
    assign b_link[0][3] = b_col3;

    for (genvar i = 0; i < n_dim; i++) begin : g_row
        for (genvar j = 0; j < n_dim; j++) begin : g_col
            pe u_pe (
                .clk   (clk),
                .reset (reset),
                .clear (clear),
                .a_in  (a_link[i][j]),
                .b_in  (b_link[i][j]),
                .a_out (a_link[i][j+1]),
                .b_out (b_link[i+1][j]),
                .acc   (cell_acc[i][j])
            );

            // Row-major packing, element (0,0) at the top.
            assign result[acc_w*(n_dim*n_dim-1-(i*n_dim+j)) +: acc_w] = cell_acc[i][j];
        end
    end

endmodule

// File: systolic_array/pe.sv
`timescale 1ns/100ps

module pe
    import systolic_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  clear,
    input  elem_t a_in,
    input  elem_t b_in,
    output elem_t a_out,
    output elem_t b_out,
    output acc_t  acc
);

    acc_t product;

    // 8x8 product fits easily in the accumulator width.
    assign product = acc_t'(a_in) * acc_t'(b_in);

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            a_out <= '0;
            b_out <= '0;
            acc <= '0;
        end else begin
            a_out <= a_in;          // Pass east.
            b_out <= b_in;          // Pass south.
            acc <= acc + product;
        end
    end

endmodule

// File: design/data_feeder.sv
`timescale 1ns/100ps

module data_feeder
    import systolic_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  load,
    input  logic  enable,
    input  lane_t data_in,
    output elem_t data_out
);

    lane_t lane;

    always_ff @(posedge clk) begin
        if (reset) begin
            lane <= '0;
            data_out <= '0;
        end else if (load) begin
            lane <= data_in;
            data_out <= '0;
        end else if (enable) begin
            // Top byte goes out first, zeros come in at the bottom.
            data_out <= lane[lane_w-1 -: elem_w];
            lane <= {lane[lane_w-elem_w-1:0], {elem_w{1'b0}}};
        end else begin
            data_out <= '0;   // Idle lanes feed zeros into the grid.
        end
    end

endmodule

// File: common/systolic_pkg.sv
package systolic_pkg;

    // Array geometry.
    localparam int n_dim = 4;
    localparam int elem_w = 8;
    localparam int acc_w = 32;

    // One skewed lane has n_dim data bytes plus n_dim-1 zero slots.
    localparam int lane_w = elem_w * (2 * n_dim - 1);

    // Last operand pair reaches the far corner after 3+3+3 steps.
    localparam int run_cycles = 3 * (n_dim - 1) + 1;

    typedef logic [elem_w-1:0] elem_t;
    typedef logic [acc_w-1:0] acc_t;
    typedef logic [lane_w-1:0] lane_t;

    // Row-major matrices, element (0,0) in the top bits.
    typedef logic [n_dim*n_dim*elem_w-1:0] matrix_in_t;
    typedef logic [n_dim*n_dim*acc_w-1:0] result_t;

    typedef logic [3:0] run_cnt_t;

    typedef enum logic [1:0] {
        st_idle,
        st_load,
        st_run,
        st_finish
    } ctrl_state_t;

endpackage
